//--- common/icache_config.svh
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// address width of the fetch and memory ports
`define XLEN 32

// direct-mapped geometry, 8 byte lines
`define ICACHE_LINES 32
`define ICACHE_OFFSET_BITS 3
`define ICACHE_TAG_MSB 15     // tag stops at this address bit

// outstanding prefetch ring, power of two
`define PREFETCH_DEPTH 4

// width of the memory transaction tag
`define MEM_TAG_BITS 4

`endif

//--- common/fetch_pkg.sv
`include "icache_config.svh"

package fetch_pkg;

    // address as seen on the fetch and memory ports
    typedef logic [`XLEN-1:0] addr_t;

    // memory command, only loads are issued from the fetch side
    typedef enum logic [1:0] {
        BUS_NONE = 2'b00,
        BUS_LOAD = 2'b01
    } bus_command_t;

    // transaction tag, zero = refused / nothing returning
    typedef logic [`MEM_TAG_BITS-1:0] mem_tag_t;

    // one cache line, as moved on the memory port
    typedef logic [63:0] cache_line_t;

    // register index of the control block
    typedef enum logic [1:0] {
        CSR_CONTROL    = 2'd0,  // bit 0 prefetch enable
        CSR_FLUSH      = 2'd1,  // write only strobe
        CSR_LOAD_COUNT = 2'd2   // read only
    } csr_index_t;

    // register data word
    typedef logic [31:0] csr_word_t;

endpackage

//--- icache/prefetch_ring.sv
`timescale 1ns/1ns
`include "icache_config.svh"

module prefetch_ring (
    input  logic                clock,
    input  logic                reset,
    input  logic                alloc,           // request a new next-line entry
    input  fetch_pkg::addr_t    alloc_addr,
    input  logic                issue_accept,    // memory took the pending request
    input  fetch_pkg::mem_tag_t issue_tag,
    input  fetch_pkg::mem_tag_t mem_return_tag,
    output logic                issue_pending,
    output fetch_pkg::addr_t    issue_addr,
    output logic                fill,
    output fetch_pkg::addr_t    fill_addr
);

    localparam int PTR_BITS = $clog2(`PREFETCH_DEPTH);

    fetch_pkg::addr_t          entry_addr [`PREFETCH_DEPTH];
    fetch_pkg::mem_tag_t       entry_tag  [`PREFETCH_DEPTH];
    logic [`PREFETCH_DEPTH-1:0] entry_valid;
    logic [`PREFETCH_DEPTH-1:0] entry_sent;

    logic [PTR_BITS-1:0] alloc_ptr;    // next free slot
    logic [PTR_BITS-1:0] issue_ptr;    // oldest not yet sent
    logic [PTR_BITS-1:0] answer_ptr;   // oldest sent, waiting for data

    logic alloc_ok;

    // slot busy means the prefetch is simply skipped
    assign alloc_ok = alloc && !entry_valid[alloc_ptr];

    assign issue_pending = entry_valid[issue_ptr] && !entry_sent[issue_ptr];
    assign issue_addr    = entry_addr[issue_ptr];

    // answers come back in issue order, only the oldest can match
    assign fill = entry_valid[answer_ptr] && entry_sent[answer_ptr]
               && (mem_return_tag != '0) && (entry_tag[answer_ptr] == mem_return_tag);
    assign fill_addr = entry_addr[answer_ptr];

    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid <= '0;
            entry_sent  <= '0;
            alloc_ptr   <= '0;
            issue_ptr   <= '0;
            answer_ptr  <= '0;
        end else begin
            if (alloc_ok) begin
                entry_valid[alloc_ptr] <= 1'b1;
                alloc_ptr              <= alloc_ptr + 1'b1;
            end
            if (issue_accept) begin
                entry_sent[issue_ptr] <= 1'b1;
                issue_ptr             <= issue_ptr + 1'b1;
            end
            // free the slot once its line is written
            if (fill) begin
                entry_valid[answer_ptr] <= 1'b0;
                entry_sent[answer_ptr]  <= 1'b0;
                answer_ptr              <= answer_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (alloc_ok) begin
            entry_addr[alloc_ptr] <= alloc_addr;
        end
        if (issue_accept) begin
            entry_tag[issue_ptr] <= issue_tag;    // tag handed out by memory
        end
    end

endmodule

//--- icache/icache.sv
`timescale 1ns/1ns
`include "icache_config.svh"

module icache (
    input  logic                     clock,
    input  logic                     reset,
    input  fetch_pkg::addr_t         fetch_addr,
    input  fetch_pkg::mem_tag_t      mem_response,
    input  fetch_pkg::mem_tag_t      mem_return_tag,
    input  fetch_pkg::cache_line_t   mem_return_data,
    input  logic                     prefetch_enable,
    input  logic                     flush,
    output fetch_pkg::cache_line_t   fetch_data,
    output logic                     fetch_valid,
    output fetch_pkg::bus_command_t  mem_command,
    output fetch_pkg::addr_t         mem_addr,
    output logic                     load_accepted
);

    localparam int INDEX_BITS = $clog2(`ICACHE_LINES);
    localparam int INDEX_LSB  = `ICACHE_OFFSET_BITS;
    localparam int TAG_LSB    = INDEX_LSB + INDEX_BITS;
    localparam int TAG_BITS   = `ICACHE_TAG_MSB + 1 - TAG_LSB;

    // line storage
    fetch_pkg::cache_line_t   data_array [`ICACHE_LINES];
    logic [TAG_BITS-1:0]      tag_array  [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0] valid_array;

    fetch_pkg::addr_t      line_addr;
    logic [INDEX_BITS-1:0] cur_index, last_index, fill_index;
    logic [TAG_BITS-1:0]   cur_tag, last_tag, fill_tag;

    logic                changed_addr;
    logic                miss_outstanding;   // demand load still to be accepted
    logic                demand_load;
    logic                ring_load;
    logic                demand_write;
    fetch_pkg::mem_tag_t demand_tag;        // zero when no demand data expected

    logic             prefetch_req;
    fetch_pkg::addr_t prefetch_addr;

    // ring side
    logic             alloc;
    logic             issue_accept;
    logic             issue_pending;
    logic             fill;
    fetch_pkg::addr_t issue_addr;
    fetch_pkg::addr_t fill_addr;

    assign line_addr = {fetch_addr[`XLEN-1:INDEX_LSB], {INDEX_LSB{1'b0}}};
    assign cur_index = fetch_addr[INDEX_LSB +: INDEX_BITS];
    assign cur_tag   = fetch_addr[`ICACHE_TAG_MSB:TAG_LSB];

    assign fill_index = fill_addr[INDEX_LSB +: INDEX_BITS];
    assign fill_tag   = fill_addr[`ICACHE_TAG_MSB:TAG_LSB];

    // hit path, same cycle
    assign fetch_valid = valid_array[cur_index] && (tag_array[cur_index] == cur_tag);
    assign fetch_data  = data_array[cur_index];

    assign changed_addr = (cur_index != last_index) || (cur_tag != last_tag);

    // demand load owns the port, the ring fills idle cycles
    assign demand_load = miss_outstanding && !changed_addr;
    assign ring_load   = !demand_load && issue_pending;

    assign mem_command = (demand_load || ring_load) ? fetch_pkg::BUS_LOAD : fetch_pkg::BUS_NONE;
    assign mem_addr    = demand_load ? line_addr : issue_addr;

    assign load_accepted = (demand_load || ring_load) && (mem_response != '0);
    assign issue_accept  = ring_load && (mem_response != '0);

    // return for the current address only, stale data is dropped
    assign demand_write = (demand_tag != '0) && (mem_return_tag == demand_tag) && !changed_addr;

    assign alloc = prefetch_req && prefetch_enable;

    prefetch_ring ring0 (
        .clock          (clock),
        .reset          (reset),
        .alloc          (alloc),
        .alloc_addr     (prefetch_addr),
        .issue_accept   (issue_accept),
        .issue_tag      (mem_response),
        .mem_return_tag (mem_return_tag),
        .issue_pending  (issue_pending),
        .issue_addr     (issue_addr),
        .fill           (fill),
        .fill_addr      (fill_addr)
    );

    always_ff @(posedge clock) begin
        if (reset) begin
            last_index       <= '1;    // forces a "change" on the first address
            last_tag         <= '1;
            miss_outstanding <= 1'b0;
            demand_tag       <= '0;
            prefetch_req     <= 1'b0;
            valid_array      <= '0;
        end else begin
            last_index <= cur_index;
            last_tag   <= cur_tag;

            if (changed_addr) begin
                miss_outstanding <= !fetch_valid;
            end else if (demand_load && (mem_response != '0)) begin
                miss_outstanding <= 1'b0;
            end

            if (demand_load && (mem_response != '0)) begin
                demand_tag <= mem_response;
            end else if (changed_addr || demand_write) begin
                demand_tag <= '0;
            end

            prefetch_req <= changed_addr && !fetch_valid;   // next line of a miss

            if (flush) begin
                valid_array <= '0;
            end else if (fill) begin
                valid_array[fill_index] <= 1'b1;
            end else if (demand_write) begin
                valid_array[cur_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        prefetch_addr <= line_addr + 'd8;

        // ring fill wins over the demand return
        if (fill) begin
            data_array[fill_index] <= mem_return_data;
            tag_array[fill_index]  <= fill_tag;
        end else if (demand_write) begin
            data_array[cur_index] <= mem_return_data;
            tag_array[cur_index]  <= cur_tag;
        end
    end

endmodule

//--- rtl/icache_csr.sv
`timescale 1ns/1ns

module icache_csr (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  cfg_write,       // one cycle write strobe
    input  fetch_pkg::csr_index_t cfg_index,
    input  fetch_pkg::csr_word_t  cfg_wdata,
    input  logic                  load_accepted,
    output fetch_pkg::csr_word_t  cfg_rdata,
    output logic                  prefetch_enable,
    output logic                  flush
);

    fetch_pkg::csr_word_t load_count;

    // flush is a pulse straight from the write strobe
    assign flush = cfg_write && (cfg_index == fetch_pkg::CSR_FLUSH);

    always_ff @(posedge clock) begin
        if (reset) begin
            prefetch_enable <= 1'b1;    // prefetch on out of reset
            load_count      <= '0;
        end else begin
            if (cfg_write && (cfg_index == fetch_pkg::CSR_CONTROL)) begin
                prefetch_enable <= cfg_wdata[0];
            end
            if (load_accepted) begin
                load_count <= load_count + 1'b1;
            end
        end
    end

    // read mux
    always_comb begin
        case (cfg_index)
            fetch_pkg::CSR_CONTROL: begin
                cfg_rdata = {31'b0, prefetch_enable};
            end
            fetch_pkg::CSR_LOAD_COUNT: begin
                cfg_rdata = load_count;
            end
            default: begin
                cfg_rdata = '0;    // flush index reads as zero
            end
        endcase
    end

endmodule

//--- rtl/fetch_top.sv
`timescale 1ns/1ns

module fetch_top (
    input  logic                    clock,
    input  logic                    reset,
    // processor side
    input  fetch_pkg::addr_t        fetch_addr,
    output fetch_pkg::cache_line_t  fetch_data,
    output logic                    fetch_valid,
    // memory side
    output fetch_pkg::bus_command_t mem_command,
    output fetch_pkg::addr_t        mem_addr,
    input  fetch_pkg::mem_tag_t     mem_response,
    input  fetch_pkg::mem_tag_t     mem_return_tag,
    input  fetch_pkg::cache_line_t  mem_return_data,
    // register access
    input  logic                    cfg_write,
    input  fetch_pkg::csr_index_t   cfg_index,
    input  fetch_pkg::csr_word_t    cfg_wdata,
    output fetch_pkg::csr_word_t    cfg_rdata
);

    logic prefetch_enable;
    logic flush;
    logic load_accepted;

    icache icache0 (
        .clock           (clock),
        .reset           (reset),
        .fetch_addr      (fetch_addr),
        .mem_response    (mem_response),
        .mem_return_tag  (mem_return_tag),
        .mem_return_data (mem_return_data),
        .prefetch_enable (prefetch_enable),
        .flush           (flush),
        .fetch_data      (fetch_data),
        .fetch_valid     (fetch_valid),
        .mem_command     (mem_command),
        .mem_addr        (mem_addr),
        .load_accepted   (load_accepted)
    );

    icache_csr csr0 (
        .clock           (clock),
        .reset           (reset),
        .cfg_write       (cfg_write),
        .cfg_index       (cfg_index),
        .cfg_wdata       (cfg_wdata),
        .load_accepted   (load_accepted),
        .cfg_rdata       (cfg_rdata),
        .prefetch_enable (prefetch_enable),
        .flush           (flush)
    );

endmodule

//--- testbench/fetch_checker.sv
`timescale 1ns/1ns
`include "icache_config.svh"

module fetch_checker (
    input logic                    clock,
    input logic                    reset,
    input fetch_pkg::addr_t        fetch_addr,
    input fetch_pkg::cache_line_t  fetch_data,
    input logic                    fetch_valid,
    input fetch_pkg::bus_command_t mem_command
);

    localparam int unsigned MAX_FILL_WAIT = 40;   // refusal runs stay well below this

    int unsigned fail_count = 0;
    logic        reset_q = 1'b0;
    int unsigned wait_cycles = 0;

    fetch_pkg::addr_t       last_addr;
    fetch_pkg::addr_t       aligned;
    fetch_pkg::cache_line_t expected_line;

    // memory rule: inverted address on top, address below
    assign aligned       = {fetch_addr[`XLEN-1:`ICACHE_OFFSET_BITS], {`ICACHE_OFFSET_BITS{1'b0}}};
    assign expected_line = {~aligned, aligned};

    always @(posedge clock) begin
        reset_q   <= reset;
        last_addr <= fetch_addr;
        // cycles spent without a hit since the address last moved
        if (reset || fetch_valid || (fetch_addr != last_addr)) begin
            wait_cycles <= 0;
        end else begin
            wait_cycles <= wait_cycles + 1;
        end
    end

    data_follows_rule: assert property (@(posedge clock) disable iff (reset)
        fetch_valid |-> (fetch_data == expected_line))
        else begin
            fail_count++;
            $error("mismatch fetch_data: expected %h actual %h",
                   $sampled(expected_line), $sampled(fetch_data));
        end

    // second reset cycle and the first cycle after it
    quiet_after_reset: assert property (@(posedge clock)
        reset_q |-> (mem_command == fetch_pkg::BUS_NONE))
        else begin
            fail_count++;
            $error("mismatch mem_command after reset: expected %0d actual %0d",
                   fetch_pkg::BUS_NONE, $sampled(mem_command));
        end

    fill_in_time: assert property (@(posedge clock) disable iff (reset)
        wait_cycles <= MAX_FILL_WAIT)
        else begin
            fail_count++;
            $error("fetch_valid stayed low for more than %0d cycles on one address",
                   MAX_FILL_WAIT);
        end

endmodule

bind fetch_top fetch_checker checker0 (
    .clock       (clock),
    .reset       (reset),
    .fetch_addr  (fetch_addr),
    .fetch_data  (fetch_data),
    .fetch_valid (fetch_valid),
    .mem_command (mem_command)
);

//--- testbench/fetch_tb.sv
`timescale 1ns/1ns
`include "icache_config.svh"

module fetch_tb;

    localparam logic [31:0] LFSR_SEED = 32'h9d16_c109;
    localparam int unsigned TIMEOUT_CYCLES = 4000;  // sequence needs a few hundred
    localparam int          FILL_LIMIT = 60;        // per fetch, above the checker bound
    localparam int unsigned RETURN_DELAY = 4;
    localparam logic [31:0] LINE_A = 32'h0000_1240;
    localparam logic [31:0] LINE_B = 32'h0000_2380;

    logic                    clock;
    logic                    reset;
    fetch_pkg::addr_t        fetch_addr;
    fetch_pkg::cache_line_t  fetch_data;
    logic                    fetch_valid;
    fetch_pkg::bus_command_t mem_command;
    fetch_pkg::addr_t        mem_addr;
    fetch_pkg::mem_tag_t     mem_response;
    fetch_pkg::mem_tag_t     mem_return_tag = '0;
    fetch_pkg::cache_line_t  mem_return_data = '0;
    logic                    cfg_write;
    fetch_pkg::csr_index_t   cfg_index;
    fetch_pkg::csr_word_t    cfg_wdata;
    fetch_pkg::csr_word_t    cfg_rdata;

    // memory model state
    logic                accept_now = 1'b1;
    fetch_pkg::mem_tag_t next_tag = 4'd1;
    logic [31:0]         mem_lfsr = LFSR_SEED;
    int unsigned         due_q[$];
    fetch_pkg::mem_tag_t tag_q[$];
    fetch_pkg::addr_t    addr_q[$];
    int unsigned         model_loads = 0;
    int unsigned         cycle = 0;
    int unsigned         watch_hits = 0;     // load attempts seen at watch_addr
    int unsigned         watch_base;
    fetch_pkg::addr_t    watch_addr;
    logic [31:0]         addr_lfsr;
    int unsigned         errors;

    fetch_top dut0 (
        .clock           (clock),
        .reset           (reset),
        .fetch_addr      (fetch_addr),
        .fetch_data      (fetch_data),
        .fetch_valid     (fetch_valid),
        .mem_command     (mem_command),
        .mem_addr        (mem_addr),
        .mem_response    (mem_response),
        .mem_return_tag  (mem_return_tag),
        .mem_return_data (mem_return_data),
        .cfg_write       (cfg_write),
        .cfg_index       (cfg_index),
        .cfg_wdata       (cfg_wdata),
        .cfg_rdata       (cfg_rdata)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];   // taps 32 22 2 1
        return {state[30:0], feedback};
    endfunction

    // tagged memory answers in the same cycle
    assign mem_response = ((mem_command == fetch_pkg::BUS_LOAD) && accept_now) ? next_tag : '0;

    always @(posedge clock) begin : memory_model
        logic [31:0] step_one;
        logic [31:0] step_two;
        step_one = lfsr_next(mem_lfsr);
        step_two = lfsr_next(step_one);
        mem_lfsr        <= step_two;
        accept_now      <= !(step_one[0] && step_two[0]);   // refuse about one in four
        mem_return_tag  <= '0;
        mem_return_data <= '0;
        if ((mem_command == fetch_pkg::BUS_LOAD) && (mem_addr == watch_addr)) begin
            watch_hits++;
        end
        if (reset) begin
            next_tag    <= 4'd1;
            model_loads = 0;
            due_q.delete();
            tag_q.delete();
            addr_q.delete();
        end else begin
            if ((mem_command == fetch_pkg::BUS_LOAD) && (mem_response != '0)) begin
                due_q.push_back(cycle + RETURN_DELAY);
                tag_q.push_back(mem_response);
                addr_q.push_back(mem_addr);
                model_loads++;
                next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
            end
            // one return per cycle, late ones wait their turn
            if ((due_q.size() > 0) && (due_q[0] <= cycle)) begin
                mem_return_tag  <= tag_q[0];
                mem_return_data <= {~addr_q[0], addr_q[0]};
                void'(due_q.pop_front());
                void'(tag_q.pop_front());
                void'(addr_q.pop_front());
            end
        end
    end

    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (cycle == TIMEOUT_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycle);
            $display("Test failed");
            $finish;
        end
    end

    task automatic check_equal(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual == expected) else begin
            errors++;
            $display("mismatch %s: expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic wait_valid(input string name);
        int waited;
        waited = 0;
        @(negedge clock);
        while (!fetch_valid && (waited < FILL_LIMIT)) begin
            @(negedge clock);
            waited++;
        end
        if (!fetch_valid) begin
            errors++;
            $display("fetch_valid never rose for %s within %0d cycles", name, FILL_LIMIT);
        end
    endtask

    task automatic fetch_line(input fetch_pkg::addr_t addr, input string name);
        @(posedge clock);
        fetch_addr <= addr;
        wait_valid(name);
    endtask

    task automatic csr_write(input fetch_pkg::csr_index_t index, input logic [31:0] data);
        @(posedge clock);
        cfg_write <= 1'b1;
        cfg_index <= index;
        cfg_wdata <= data;
        @(posedge clock);
        cfg_write <= 1'b0;
    endtask

    task automatic csr_read(input fetch_pkg::csr_index_t index, output logic [31:0] data);
        @(posedge clock);
        cfg_index <= index;
        @(negedge clock);
        data = cfg_rdata;
    endtask

    // called between edges only
    task automatic watch_loads(input fetch_pkg::addr_t addr);
        watch_addr = addr;
        watch_base = watch_hits;
    endtask

    function automatic int unsigned loads_seen();
        return watch_hits - watch_base;
    endfunction

    task automatic random_line(output fetch_pkg::addr_t addr);
        addr = '0;
        for (int i = 3; i <= `ICACHE_TAG_MSB; i++) begin
            addr_lfsr = lfsr_next(addr_lfsr);
            addr[i]   = addr_lfsr[0];
        end
    endtask

    initial begin : stimulus
        logic [31:0]      word;
        fetch_pkg::addr_t addr;
        fetch_addr = '0;
        cfg_write  = 1'b0;
        cfg_index  = fetch_pkg::CSR_CONTROL;
        cfg_wdata  = '0;
        reset      = 1'b1;
        errors     = 0;
        watch_addr = '1;    // never a line address
        watch_base = 0;
        addr_lfsr  = LFSR_SEED;
        repeat (2) @(posedge clock);
        reset <= 1'b0;

        // next line already filled by the prefetcher
        fetch_line(LINE_A, "demand_a");
        repeat (30) @(negedge clock);
        watch_loads(LINE_A + 32'd8);
        @(posedge clock);
        fetch_addr <= LINE_A + 32'd8;
        @(negedge clock);
        check_equal("prefetch_hit", 64'd1, 64'(fetch_valid));
        repeat (20) @(negedge clock);
        check_equal("prefetch_no_reload", 64'd0, 64'(loads_seen()));

        // prefetch off, the next line is a plain miss
        csr_write(fetch_pkg::CSR_CONTROL, 32'd0);
        csr_read(fetch_pkg::CSR_CONTROL, word);
        check_equal("control_off", 64'd0, 64'(word));
        fetch_line(LINE_B, "demand_b");
        watch_loads(LINE_B + 32'd8);
        fetch_line(LINE_B + 32'd8, "demand_b_next");
        check_equal("no_prefetch_load", 64'd1, 64'(loads_seen() != 0));

        // flush, then line A misses again
        watch_loads(LINE_A);
        csr_write(fetch_pkg::CSR_FLUSH, 32'd0);
        fetch_addr <= LINE_A;
        @(negedge clock);
        check_equal("flush_miss", 64'd0, 64'(fetch_valid));
        wait_valid("refetch_a");
        check_equal("flush_reload", 64'd1, 64'(loads_seen() != 0));

        csr_write(fetch_pkg::CSR_CONTROL, 32'd1);
        csr_read(fetch_pkg::CSR_CONTROL, word);
        check_equal("control_on", 64'd1, 64'(word));
        for (int n = 0; n < 8; n++) begin
            random_line(addr);
            fetch_line(addr, "random_line");
        end

        csr_read(fetch_pkg::CSR_LOAD_COUNT, word);
        check_equal("load_count", 64'(model_loads), 64'(word));

        $display("checks done: %0d testbench errors, %0d assertion failures",
                 errors, dut0.checker0.fail_count);
        if ((errors == 0) && (dut0.checker0.fail_count == 0)) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+common
common/fetch_pkg.sv
icache/prefetch_ring.sv
icache/icache.sv
rtl/icache_csr.sv
rtl/fetch_top.sv
testbench/fetch_checker.sv
testbench/fetch_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := common/icache_config.svh

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-$(BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then echo "no result in $(LOG)"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
